//--- rtl/qam_tx_pkg.sv
package qam_tx_pkg;

    // datapath word, signed 1s17
    localparam int SAMPLE_W = 18;

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // baseband pair, used for mapper output and filter outputs
    typedef struct packed {
        sample_t i;
        sample_t q;
    } iq_sample_t;

    // rail fields of one 16-QAM symbol
    typedef struct packed {
        logic [1:0] i_bits;
        logic [1:0] q_bits;
    } symbol_fields_t;

    // same nibble, seen raw or split per rail
    typedef union packed {
        logic [3:0]     raw;
        symbol_fields_t fields;
    } symbol_t;

    // gray coded levels, indexed by the 2-bit field
    // 00 -> -3/4, 01 -> -1/4, 11 -> +1/4, 10 -> +3/4
    localparam sample_t LEVEL_TABLE [4] = '{
        -18'sd98304,
        -18'sd32768,
        18'sd98304,
        18'sd32768
    };

    localparam int DEFAULT_TAPS = 21;

    // half of a root raised cosine style set, h[10] is the center tap
    localparam sample_t DEFAULT_COEFFS [11] = '{
        -18'sd400,
        18'sd1600,
        18'sd2900,
        18'sd1200,
        -18'sd3100,
        -18'sd6200,
        -18'sd3800,
        18'sd6400,
        18'sd21500,
        18'sd35200,
        18'sd40960
    };

endpackage

//--- rtl/qam_symbol_mapper.sv
module qam_symbol_mapper (
    input  logic                   sys_clk,
    input  logic                   reset,
    input  logic                   sam_clk_en,
    input  qam_tx_pkg::symbol_t    symbol,
    output qam_tx_pkg::iq_sample_t mapped
);

    // true when v is one of the four constellation levels
    function automatic logic is_level(qam_tx_pkg::sample_t v);
        logic hit;
        hit = 1'b0;
        for (int n = 0; n < 4; n++) begin
            if (v == qam_tx_pkg::LEVEL_TABLE[n]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // one lookup per rail, registered on the strobe
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            mapped <= '0;
        end else if (sam_clk_en) begin
            mapped.i <= qam_tx_pkg::LEVEL_TABLE[symbol.fields.i_bits];
            mapped.q <= qam_tx_pkg::LEVEL_TABLE[symbol.fields.q_bits];
        end
    end

    // only the reset value may sit outside the constellation
    assert property (@(posedge sys_clk) disable iff (reset)
        is_level(mapped.i) || (mapped.i == '0))
        else $error("qam_symbol_mapper: mapped.i is not a valid level");

endmodule

//--- rtl/fir_symmetric.sv
module fir_symmetric #(
    parameter int                  TAPS = qam_tx_pkg::DEFAULT_TAPS,
    parameter qam_tx_pkg::sample_t COEFFS [(TAPS + 1) / 2] = qam_tx_pkg::DEFAULT_COEFFS
) (
    input  logic                sys_clk,
    input  logic                reset,
    input  logic                sam_clk_en,
    input  qam_tx_pkg::sample_t x_in,
    output qam_tx_pkg::sample_t y
);

    // coefficient pairs, the last one is the center tap
    localparam int NP     = (TAPS + 1) / 2;
    localparam int CENTER = NP - 1;
    localparam int LEVELS = $clog2(NP);
    localparam int PROD_W = 2 * qam_tx_pkg::SAMPLE_W;

    // number of inputs seen by tree level lvl
    function automatic int level_width(int lvl);
        int w;
        w = NP;
        for (int n = 0; n < lvl; n++) begin
            w = (w + 1) / 2;
        end
        return w;
    endfunction

    qam_tx_pkg::sample_t      x [TAPS];
    qam_tx_pkg::sample_t      p [NP];
    logic signed [PROD_W-1:0] prod [NP];
    qam_tx_pkg::sample_t      tree_in [LEVELS][2*NP];
    qam_tx_pkg::sample_t      sum_lvl [LEVELS][NP];

    if (((TAPS % 2) == 0) || (TAPS < 3)) begin : g_bad_taps
        $error("fir_symmetric: TAPS must be odd and at least 3");
    end

    // input scaled to 2s16 so the pre-add has headroom
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int k = 0; k < TAPS; k++) begin
                x[k] <= '0;
            end
        end else if (sam_clk_en) begin
            x[0] <= x_in >>> 1;
            for (int k = 1; k < TAPS; k++) begin
                x[k] <= x[k-1];
            end
        end
    end

    // fold mirrored taps, center tap passes alone
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int k = 0; k < NP; k++) begin
                p[k] <= '0;
            end
        end else if (sam_clk_en) begin
            for (int k = 0; k < CENTER; k++) begin
                p[k] <= x[k] + x[TAPS-1-k];
            end
            p[CENTER] <= x[CENTER];
        end
    end

    always_comb begin
        for (int k = 0; k < NP; k++) begin
            prod[k] = p[k] * COEFFS[k];
        end
    end

    // zero padded inputs per level, odd last element adds zero
    always_comb begin
        for (int l = 0; l < LEVELS; l++) begin
            for (int i = 0; i < 2 * NP; i++) begin
                tree_in[l][i] = '0;
            end
        end
        for (int i = 0; i < NP; i++) begin
            // product bits 33..16 back to 18 bits
            tree_in[0][i] = prod[i][PROD_W-3:qam_tx_pkg::SAMPLE_W-2];
        end
        for (int l = 1; l < LEVELS; l++) begin
            for (int i = 0; i < NP; i++) begin
                if (i < level_width(l)) begin
                    tree_in[l][i] = sum_lvl[l-1][i];
                end
            end
        end
    end

    // pairwise sums, wrapping at 18 bits
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            for (int l = 0; l < LEVELS; l++) begin
                for (int j = 0; j < NP; j++) begin
                    sum_lvl[l][j] <= '0;
                end
            end
        end else if (sam_clk_en) begin
            for (int l = 0; l < LEVELS; l++) begin
                for (int j = 0; j < NP; j++) begin
                    sum_lvl[l][j] <= tree_in[l][2*j] + tree_in[l][2*j+1];
                end
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            y <= '0;
        end else if (sam_clk_en) begin
            y <= sum_lvl[LEVELS-1][0];
        end
    end

    assert property (@(posedge sys_clk) disable iff (reset)
        !sam_clk_en |=> $stable(y))
        else $error("fir_symmetric: y changed without a strobe");

endmodule

//--- rtl/if_upconverter.sv
module if_upconverter (
    input  logic                   sys_clk,
    input  logic                   reset,
    input  logic                   sam_clk_en,
    input  qam_tx_pkg::iq_sample_t shaped,
    output qam_tx_pkg::sample_t    if_out,
    output logic                   if_valid
);

    // quarter turn of the carrier per strobe
    logic [1:0] phase;

    always_ff @(posedge sys_clk) begin
        if (reset) begin
            phase <= '0;
        end else if (sam_clk_en) begin
            phase <= phase + 2'd1;
        end
    end

    // cos/sin at fs/4 are only 0 and +-1, so a mux and a negate do the mixing
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            if_out <= '0;
        end else if (sam_clk_en) begin
            case (phase)
                2'd0: if_out <= shaped.i;
                2'd1: if_out <= -shaped.q;
                2'd2: if_out <= -shaped.i;
                default: if_out <= shaped.q;
            endcase
        end
    end

    // one pulse per new output word
    always_ff @(posedge sys_clk) begin
        if (reset) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= sam_clk_en;
        end
    end

    assert property (@(posedge sys_clk) disable iff (reset)
        sam_clk_en |=> (phase == $past(phase) + 2'd1))
        else $error("if_upconverter: phase did not advance by one");

endmodule

//--- rtl/qam_tx_top.sv
module qam_tx_top #(
    parameter int                  TAPS = qam_tx_pkg::DEFAULT_TAPS,
    parameter qam_tx_pkg::sample_t COEFFS [(TAPS + 1) / 2] = qam_tx_pkg::DEFAULT_COEFFS
) (
    input  logic                sys_clk,
    input  logic                reset,
    input  logic                sam_clk_en,
    input  qam_tx_pkg::symbol_t symbol,
    output qam_tx_pkg::sample_t if_out,
    output logic                if_valid
);

    // mapper levels before shaping
    qam_tx_pkg::iq_sample_t mapped;
    // pulse shaped rails into the mixer
    qam_tx_pkg::iq_sample_t shaped;

    qam_symbol_mapper u_mapper (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .symbol     (symbol),
        .mapped     (mapped)
    );

    // same filter on both rails
    fir_symmetric #(
        .TAPS   (TAPS),
        .COEFFS (COEFFS)
    ) u_fir_i (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .x_in       (mapped.i),
        .y          (shaped.i)
    );

    fir_symmetric #(
        .TAPS   (TAPS),
        .COEFFS (COEFFS)
    ) u_fir_q (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .x_in       (mapped.q),
        .y          (shaped.q)
    );

    if_upconverter u_upconv (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .shaped     (shaped),
        .if_out     (if_out),
        .if_valid   (if_valid)
    );

endmodule

//--- verif/qam_tx_tb.sv
module qam_tx_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TAPS   = qam_tx_pkg::DEFAULT_TAPS;
    localparam int NP     = (TAPS + 1) / 2;
    localparam int CENTER = NP - 1;
    localparam qam_tx_pkg::sample_t COEFFS [NP] = qam_tx_pkg::DEFAULT_COEFFS;
    // x, pre-add, tree levels and y
    localparam int FIR_LAT = 3 + $clog2(NP);

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 4;
    localparam int IDLE_CYCLES     = 3;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int SETTLE_STROBES  = 40;
    localparam int ROTATION_CYCLES = SETTLE_STROBES + 4;
    localparam int IMPULSE_CYCLES  = 2 * SETTLE_STROBES + 5;
    localparam int STALL_ROUNDS    = 6;
    localparam int STALL_CYCLES    = STALL_ROUNDS * 50;
    localparam int DRAIN_CYCLES    = 10;
    localparam int TOTAL_CYCLES    = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES
                                   + ROTATION_CYCLES + IMPULSE_CYCLES + STALL_CYCLES
                                   + DRAIN_CYCLES;

    logic                   sys_clk;
    logic                   reset;
    logic                   sam_clk_en;
    qam_tx_pkg::symbol_t    symbol;
    qam_tx_pkg::sample_t    if_out;
    logic                   if_valid;

    // reference model state
    logic [31:0]            lfsr_state;
    qam_tx_pkg::sample_t    m_lvl [2];
    qam_tx_pkg::sample_t    dline [2][TAPS];
    logic [1:0]             m_phase;
    qam_tx_pkg::iq_sample_t pipe [$];
    qam_tx_pkg::sample_t    exp_if_out;
    logic [1:0]             exp_phase;
    logic                   prev_en;
    qam_tx_pkg::sample_t    last_if_out;
    int                     diff_mode;
    qam_tx_pkg::sample_t    base_exp [4];
    qam_tx_pkg::sample_t    base_dut [4];
    int                     errors;
    int                     checks;

    qam_tx_top #(
        .TAPS   (TAPS),
        .COEFFS (COEFFS)
    ) u_dut (
        .sys_clk    (sys_clk),
        .reset      (reset),
        .sam_clk_en (sam_clk_en),
        .symbol     (symbol),
        .if_out     (if_out),
        .if_valid   (if_valid)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        #(TOTAL_CYCLES * CLK_PERIOD * 2);
        $display("watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    // right shifting galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic next_bit();
        lfsr_state = lfsr_step(lfsr_state);
        return lfsr_state[0];
    endfunction

    function automatic qam_tx_pkg::symbol_t random_symbol();
        qam_tx_pkg::symbol_t s;
        for (int b = 0; b < 4; b++) begin
            s.raw[b] = next_bit();
        end
        return s;
    endfunction

    // gray coded 16-QAM rail levels
    function automatic qam_tx_pkg::sample_t gray_level(input logic [1:0] bits);
        case (bits)
            2'b00: return -18'sd98304;
            2'b01: return -18'sd32768;
            2'b11: return 18'sd32768;
            default: return 18'sd98304;
        endcase
    endfunction

    // folded FIR on one rail's delay line, 18-bit wrap at every add
    function automatic qam_tx_pkg::sample_t fir_model(input int rail);
        qam_tx_pkg::sample_t vals [NP];
        qam_tx_pkg::sample_t pre;
        logic signed [35:0]  prod;
        int                  w;
        for (int k = 0; k < NP; k++) begin
            if (k == CENTER) begin
                pre = dline[rail][k];
            end else begin
                pre = dline[rail][k] + dline[rail][TAPS-1-k];
            end
            prod = 36'(pre) * 36'(COEFFS[k]);
            vals[k] = prod[33:16];
        end
        w = NP;
        while (w > 1) begin
            for (int j = 0; j < (w + 1) / 2; j++) begin
                if (2 * j + 1 < w) begin
                    vals[j] = vals[2*j] + vals[2*j+1];
                end else begin
                    vals[j] = vals[2*j];
                end
            end
            w = (w + 1) / 2;
        end
        return vals[0];
    endfunction

    // i, -q, -i, +q over the four carrier phases
    function automatic qam_tx_pkg::sample_t rotate_fs4(input qam_tx_pkg::iq_sample_t s,
                                                        input logic [1:0] ph);
        case (ph)
            2'd0: return s.i;
            2'd1: return -s.q;
            2'd2: return -s.i;
            default: return s.q;
        endcase
    endfunction

    task automatic model_reset();
        qam_tx_pkg::iq_sample_t zero;
        zero = '0;
        for (int r = 0; r < 2; r++) begin
            m_lvl[r] = '0;
            for (int k = 0; k < TAPS; k++) begin
                dline[r][k] = '0;
            end
        end
        m_phase = '0;
        exp_phase = '0;
        exp_if_out = '0;
        prev_en = 1'b0;
        last_if_out = '0;
        pipe.delete();
        // pipeline registers after reset
        repeat (FIR_LAT - 1) pipe.push_back(zero);
    endtask

    // one strobe, exp_if_out is the value seen after the coming edge
    task automatic model_strobe(input qam_tx_pkg::symbol_t sym);
        qam_tx_pkg::iq_sample_t now;
        qam_tx_pkg::iq_sample_t due;
        now.i = fir_model(0);
        now.q = fir_model(1);
        pipe.push_back(now);
        due = pipe.pop_front();
        exp_if_out = rotate_fs4(due, m_phase);
        exp_phase = m_phase;
        m_phase = m_phase + 2'd1;
        for (int r = 0; r < 2; r++) begin
            for (int k = TAPS - 1; k > 0; k--) begin
                dline[r][k] = dline[r][k-1];
            end
            dline[r][0] = m_lvl[r] >>> 1;
        end
        m_lvl[0] = gray_level(sym.fields.i_bits);
        m_lvl[1] = gray_level(sym.fields.q_bits);
    endtask

    task automatic check_value(input string name, input qam_tx_pkg::sample_t expected,
                               input qam_tx_pkg::sample_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_outputs(input string test);
        qam_tx_pkg::sample_t diff_exp;
        qam_tx_pkg::sample_t diff_dut;
        check_value({test, " if_valid"}, {17'b0, prev_en}, {17'b0, if_valid});
        check_value($sformatf("%s if_out ph%0d", test, exp_phase), exp_if_out, if_out);
        if (!if_valid) begin
            check_value({test, " if_out hold"}, last_if_out, if_out);
        end
        last_if_out = if_out;
        if (diff_mode == 1) begin
            base_exp[exp_phase] = exp_if_out;
            base_dut[exp_phase] = if_out;
        end else if (diff_mode == 2) begin
            diff_exp = exp_if_out - base_exp[exp_phase];
            diff_dut = if_out - base_dut[exp_phase];
            check_value("impulse diff", diff_exp, diff_dut);
        end
    endtask

    // check the last edge, then drive the next one
    task automatic run_cycle(input logic en, input qam_tx_pkg::symbol_t sym,
                             input string test);
        @(negedge sys_clk);
        check_outputs(test);
        sam_clk_en = en;
        symbol = sym;
        if (en) begin
            model_strobe(sym);
        end
        prev_en = en;
    endtask

    initial begin
        qam_tx_pkg::symbol_t    sym;
        qam_tx_pkg::symbol_t    base_sym;
        qam_tx_pkg::symbol_t    pulse_sym;
        qam_tx_pkg::symbol_t    rot_sym;
        qam_tx_pkg::iq_sample_t steady;
        logic                   en;
        errors = 0;
        checks = 0;
        diff_mode = 0;
        lfsr_state = 32'hccdf_f2ad;
        reset = 1'b1;
        sam_clk_en = 1'b0;
        symbol = '0;
        model_reset();
        repeat (RESET_CYCLES) @(negedge sys_clk);
        reset = 1'b0;

        repeat (IDLE_CYCLES) run_cycle(1'b0, '0, "after_reset");

        sym = '0;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            en = next_bit();
            if (en) begin
                sym = random_symbol();
            end
            run_cycle(en, sym, "random");
        end

        // unequal rails so a swapped rail or a wrong sign shows up
        rot_sym.raw = 4'b0001;
        repeat (SETTLE_STROBES) run_cycle(1'b1, rot_sym, "rotation");
        steady.i = fir_model(0);
        steady.q = fir_model(1);
        diff_mode = 1;
        repeat (4) run_cycle(1'b1, rot_sym, "rotation");
        diff_mode = 0;
        for (int p = 0; p < 4; p++) begin
            check_value($sformatf("rotation ph%0d", p), rotate_fs4(steady, 2'(p)),
                        base_dut[p]);
        end

        // settle on a constant symbol, then a single pulse on the i rail
        base_sym.raw = 4'b0000;
        pulse_sym.raw = 4'b1000;
        repeat (SETTLE_STROBES) run_cycle(1'b1, base_sym, "impulse");
        diff_mode = 1;
        repeat (4) run_cycle(1'b1, base_sym, "impulse");
        diff_mode = 2;
        run_cycle(1'b1, pulse_sym, "impulse");
        repeat (SETTLE_STROBES) run_cycle(1'b1, base_sym, "impulse");
        diff_mode = 0;

        for (int r = 0; r < STALL_ROUNDS; r++) begin
            repeat (10) begin
                sym = random_symbol();
                run_cycle(1'b1, sym, "stall");
            end
            // symbol keeps changing while no strobe comes
            repeat (40) begin
                sym = random_symbol();
                run_cycle(1'b0, sym, "stall");
            end
        end
        repeat (DRAIN_CYCLES) run_cycle(1'b0, sym, "drain");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- filelist.f
rtl/qam_tx_pkg.sv
rtl/qam_symbol_mapper.sv
rtl/fir_symmetric.sv
rtl/if_upconverter.sv
rtl/qam_tx_top.sv
verif/qam_tx_tb.sv

//--- Makefile
TOP := qam_tx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

lint:
	verilator --lint-only -Wall --timing --top-module qam_tx_top -f filelist.f

clean:
	rm -rf obj_dir
